/* vlog.f */
+incdir+tb
source/coherence_pkg.sv
source/request_arbiter.sv
source/cache_line_array.sv
source/l2_memory.sv
source/coherency_unit.sv
source/coherent_bus_top.sv
tb/coherence_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the MESI subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module coherence_tb \
    -f vlog.f -o sim_coherence
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_coherence)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TEST PASSED$"; then
    exit 0
fi
exit 1

/* tb/coherence_tb_tasks.svh */
// Testbench tasks for the MESI subsystem
// Request driver, compare tasks and the directed tests

task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                          input logic [DATA_W-1:0] act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
    end
endtask

task automatic check_int(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
        errors++;
        $display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp, act);
    end
endtask

// One request through valid/ready, then its response checked against the model
// lat counts cycles from the transfer edge to resp_valid
task automatic send_request(input int c, input logic wr, input logic [ADDR_W-1:0] a,
                            input logic [DATA_W-1:0] d, output int lat);
    logic [DATA_W-1:0] exp;
    int                waited;
    @(negedge CLK);
    req_valid[c]     = 1'b1;
    req_write[c]     = wr;
    req_addr[c].word = a;
    req_wdata[c]     = d;
    waited           = 0;
    lat              = -1;
    #1;                               // Let ready settle after the drive
    while (!req_ready[c] && waited < TIMEOUT) begin
        @(negedge CLK);
        #1;
        waited++;
    end
    if (!req_ready[c]) begin
        errors++;
        $display("t=%0t processor %0d request was never accepted", $time, c);
        req_valid[c] = 1'b0;
        return;
    end
    @(posedge CLK);                   // Transfer edge
    if (wr)
        model[a] = d;
    exp = wr ? d : model[a];          // Writes echo their data
    @(negedge CLK);
    req_valid[c] = 1'b0;
    lat = 1;
    while (!resp_valid[c] && lat < TIMEOUT) begin
        @(negedge CLK);
        lat++;
    end
    if (!resp_valid[c]) begin
        errors++;
        $display("t=%0t processor %0d got no response", $time, c);
        lat = -1;
        return;
    end
    served.push_back(c);
    check_data($sformatf("resp_rdata[%0d]", c), exp, resp_rdata[c]);
endtask

task automatic test_reset_state();
    int e0, waited, lat;
    e0     = errors;
    waited = 0;
    @(negedge CLK);
    while (req_ready != '1 && waited < TIMEOUT) begin
        check_flag("resp_valid[0]", 1'b0, resp_valid[0]);
        check_flag("resp_valid[1]", 1'b0, resp_valid[1]);
        @(negedge CLK);
        waited++;
    end
    check_flag("req_ready[0]", 1'b1, req_ready[0]);
    check_flag("req_ready[1]", 1'b1, req_ready[1]);
    check_flag("resp_valid[0]", 1'b0, resp_valid[0]);
    check_flag("resp_valid[1]", 1'b0, resp_valid[1]);
    send_request(1, 1'b0, 16'h7a5c, '0, lat);     // Never written, model says 0
    report_test("reset_state", e0);
endtask

// M in cache 0 supplied to cache 1, both end in S
task automatic test_remote_read();
    int e0, lat;
    e0 = errors;
    send_request(0, 1'b1, 16'h0234, rand_bits(32), lat);
    send_request(1, 1'b0, 16'h0234, '0, lat);
    send_request(0, 1'b0, 16'h0234, '0, lat);
    report_test("remote_read", e0);
endtask

task automatic test_invalidation();
    int e0, lat;
    e0 = errors;
    send_request(0, 1'b1, 16'h0345, rand_bits(32), lat);
    send_request(0, 1'b0, 16'h0345, '0, lat);
    send_request(1, 1'b0, 16'h0345, '0, lat);         // Both hold S now
    send_request(1, 1'b1, 16'h0345, rand_bits(32), lat);   // S write kills cache 0 copy
    send_request(0, 1'b0, 16'h0345, '0, lat);         // Must not see the stale word
    send_request(1, 1'b0, 16'h0345, '0, lat);
    report_test("invalidation", e0);
endtask

// Same index 6, tags differ, so the second write evicts a dirty line
task automatic test_victim_writeback();
    int e0, lat;
    e0 = errors;
    send_request(0, 1'b1, 16'h0456, rand_bits(32), lat);
    send_request(0, 1'b1, 16'h0a56, rand_bits(32), lat);
    send_request(1, 1'b0, 16'h0456, '0, lat);          // Filled from L2
    send_request(1, 1'b0, 16'h0456, '0, lat);
    check_int("read hit E latency", 2, lat);
    send_request(0, 1'b0, 16'h0a56, '0, lat);
    check_int("read hit M latency", 2, lat);
    send_request(0, 1'b1, 16'h0a56, rand_bits(32), lat);
    check_int("write hit M latency", 2, lat);
    report_test("victim_writeback", e0);
endtask

task automatic test_contention();
    int                e0, lat0, lat1;
    logic [DATA_W-1:0] d0 [4];
    logic [DATA_W-1:0] d1 [4];
    e0 = errors;
    served.delete();
    for (int k = 0; k < 4; k++) begin
        d0[k] = rand_bits(32);
        d1[k] = rand_bits(32);
    end
    // Both start on the same falling edge and re-request right after each response
    fork
        for (int k = 0; k < 4; k++)
            send_request(0, k % 2 == 0, 16'h0567, d0[k], lat0);
        for (int k = 0; k < 4; k++)
            send_request(1, k % 2 == 1, 16'h0567, d1[k], lat1);
    join
    check_int("response count", 8, served.size());
    for (int k = 1; k < served.size(); k++)
        check_int("granted cpu", 1 - served[k-1], served[k]);
    report_test("contention", e0);
endtask

task automatic test_random_traffic();
    int                e0, lat0, lat1;
    logic              wr_op [CPUS][RAND_OPS];
    logic [ADDR_W-1:0] ad [CPUS][RAND_OPS];
    logic [DATA_W-1:0] dt [CPUS][RAND_OPS];
    e0 = errors;
    // Stimulus drawn up front so the LFSR order is fixed
    for (int k = 0; k < RAND_OPS; k++) begin
        for (int c = 0; c < CPUS; c++) begin
            wr_op[c][k] = rand_bits(1) != 0;
            ad[c][k]    = 16'h0100 + ADDR_W'(rand_bits(5));   // 32 words, two tags
            dt[c][k]    = rand_bits(32);
        end
    end
    fork
        for (int k = 0; k < RAND_OPS; k++)
            send_request(0, wr_op[0][k], ad[0][k], dt[0][k], lat0);
        for (int k = 0; k < RAND_OPS; k++)
            send_request(1, wr_op[1][k], ad[1][k], dt[1][k], lat1);
    join
    report_test("random_traffic", e0);
endtask

/* tb/coherence_tb.sv */
// Testbench for the two-processor MESI subsystem
// Directed coherence scenarios and random traffic checked against a word model
`timescale 1ns/10ps

module coherence_tb
    import coherence_pkg::*;
();

    localparam int TIMEOUT  = 200;   // Cycles allowed for any single wait
    localparam int RAND_OPS = 100;   // Random requests per processor

    logic              CLK;
    logic              nRST;
    logic [CPUS-1:0]   req_valid, req_ready, req_write, resp_valid;
    cache_addr_t       req_addr [CPUS];
    logic [DATA_W-1:0] req_wdata [CPUS];
    logic [DATA_W-1:0] resp_rdata [CPUS];

    bit [DATA_W-1:0]   model [L2_WORDS];    // Golden word memory, zero at start
    logic [31:0]       lfsr;
    int                checks, errors;
    int                served[$];           // Processor of each response, in order

    coherent_bus_top u_coherent_bus_top (
        .CLK, .nRST,
        .req_valid, .req_ready, .req_write, .req_addr, .req_wdata,
        .resp_valid, .resp_rdata
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
    // One step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        end
        return r;
    endfunction

    function automatic void report_test(input string name, input int err_before);
        $display("%-18s finished, %0d errors", name, errors - err_before);
    endfunction

    `include "coherence_tb_tasks.svh"

    initial begin
        nRST      = 1'b0;
        req_valid = '0;
        req_write = '0;
        for (int i = 0; i < CPUS; i++) begin
            req_addr[i]  = '0;
            req_wdata[i] = '0;
        end
        lfsr   = 32'h31acaf71;
        checks = 0;
        errors = 0;
        repeat (2) @(negedge CLK);    // Two full cycles in reset
        nRST = 1'b1;

        test_reset_state();
        test_remote_read();
        test_invalidation();
        test_victim_writeback();
        test_contention();
        test_random_traffic();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* source/coherent_bus_top.sv */
// Two-processor MESI subsystem top
// Arbiter, coherency unit, two private caches and shared L2
`timescale 1ns/10ps

module coherent_bus_top
    import coherence_pkg::*;
(
    input  logic              CLK,
    input  logic              nRST,
    input  logic [CPUS-1:0]   req_valid,
    output logic [CPUS-1:0]   req_ready,
    input  logic [CPUS-1:0]   req_write,
    input  cache_addr_t       req_addr [CPUS],
    input  logic [DATA_W-1:0] req_wdata [CPUS],
    output logic [CPUS-1:0]   resp_valid,
    output logic [DATA_W-1:0] resp_rdata [CPUS]
);

    logic              grant_valid, done;
    logic [CPU_W-1:0]  grant_cpu, other;
    logic [CPUS-1:0]   lk_hit, upd_en, c_apply, c_snoop_hit;
    mesi_state_t       lk_state [CPUS], upd_state [CPUS], c_snoop_state [CPUS];
    logic [DATA_W-1:0] lk_data [CPUS], upd_data [CPUS], c_snoop_data [CPUS];
    logic [TAG_W-1:0]  lk_victim_tag [CPUS], upd_tag [CPUS];
    cache_addr_t       upd_addr [CPUS];
    snoop_cmd_t        snoop_cmd, c_cmd [CPUS];
    cache_addr_t       snoop_addr, l2_addr;
    logic              snoop_apply, l2_start, l2_write, l2_done;
    logic [DATA_W-1:0] l2_wdata, l2_rdata;

    assign other = CPU_W'((int'(grant_cpu) + 1) % CPUS);   // The cache being snooped

    request_arbiter u_request_arbiter (
        .CLK, .nRST, .req_valid, .busy_done(done), .grant_valid, .grant_cpu
    );

    coherency_unit u_coherency_unit (
        .CLK, .nRST, .grant_valid, .grant_cpu,
        .req_write, .req_addr, .req_wdata, .req_ready, .resp_valid, .resp_rdata, .done,
        .lk_hit, .lk_state, .lk_data, .lk_victim_tag,
        .upd_en, .upd_tag, .upd_state, .upd_data,
        .snoop_cmd, .snoop_addr, .snoop_apply,
        .snoop_hit(c_snoop_hit[other]), .snoop_state(c_snoop_state[other]),
        .snoop_data(c_snoop_data[other]),
        .l2_start, .l2_write, .l2_addr, .l2_wdata, .l2_done, .l2_rdata
    );

    for (genvar i = 0; i < CPUS; i++) begin : g_cache
        // Requester never sees its own snoop
        assign c_cmd[i]    = grant_cpu == CPU_W'(i) ? SNOOP_NONE : snoop_cmd;
        assign c_apply[i]  = snoop_apply && grant_cpu != CPU_W'(i);
        assign upd_addr[i] = {upd_tag[i], snoop_addr.f.index};

        cache_line_array u_cache (
            .CLK, .nRST,
            .lk_addr(snoop_addr), .lk_hit(lk_hit[i]), .lk_state(lk_state[i]),
            .lk_data(lk_data[i]), .lk_victim_tag(lk_victim_tag[i]),
            .upd_en(upd_en[i]), .upd_addr(upd_addr[i]), .upd_state(upd_state[i]),
            .upd_data(upd_data[i]),
            .snoop_cmd(c_cmd[i]), .snoop_addr, .snoop_apply(c_apply[i]),
            .snoop_hit(c_snoop_hit[i]), .snoop_state(c_snoop_state[i]),
            .snoop_data(c_snoop_data[i])
        );
    end

    l2_memory u_l2_memory (
        .CLK, .nRST, .start(l2_start), .write(l2_write), .addr(l2_addr),
        .wdata(l2_wdata), .done(l2_done), .rdata(l2_rdata)
    );

endmodule

/* source/coherency_unit.sv */
// Coherency unit
// Serializes processor requests through lookup, snoop, writeback and fill
`timescale 1ns/10ps

module coherency_unit
    import coherence_pkg::*;
(
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 grant_valid,
    input  logic [CPU_W-1:0]     grant_cpu,
    input  logic [CPUS-1:0]      req_write,
    input  cache_addr_t          req_addr [CPUS],
    input  logic [DATA_W-1:0]    req_wdata [CPUS],
    output logic [CPUS-1:0]      req_ready,
    output logic [CPUS-1:0]      resp_valid,
    output logic [DATA_W-1:0]    resp_rdata [CPUS],
    output logic                 done,
    input  logic [CPUS-1:0]      lk_hit,
    input  mesi_state_t          lk_state [CPUS],
    input  logic [DATA_W-1:0]    lk_data [CPUS],
    input  logic [TAG_W-1:0]     lk_victim_tag [CPUS],
    output logic [CPUS-1:0]      upd_en,
    output logic [TAG_W-1:0]     upd_tag [CPUS],
    output mesi_state_t          upd_state [CPUS],
    output logic [DATA_W-1:0]    upd_data [CPUS],
    output snoop_cmd_t           snoop_cmd,
    output cache_addr_t          snoop_addr,
    output logic                 snoop_apply,
    input  logic                 snoop_hit,
    input  mesi_state_t          snoop_state,
    input  logic [DATA_W-1:0]    snoop_data,
    output logic                 l2_start,
    output logic                 l2_write,
    output cache_addr_t          l2_addr,
    output logic [DATA_W-1:0]    l2_wdata,
    input  logic                 l2_done,
    input  logic [DATA_W-1:0]    l2_rdata
);

    typedef enum logic [2:0] {
        IDLE, LOOKUP, SNOOP, WB_VICTIM, WB_SNOOP, FILL, RESPOND
    } cu_state_t;

    cu_state_t          state, next_state;
    logic               ready_en;    // Holds ready off for the first cycle out of reset
    logic               l2_busy;     // L2 access already started in this state
    logic [CPU_W-1:0]   cpu_q;
    cache_addr_t        addr_q;
    logic               write_q;
    logic [DATA_W-1:0]  wdata_q;
    logic               vic_q, snp_hit_q, snp_mod_q;
    logic [TAG_W-1:0]   vic_tag_q;
    logic [DATA_W-1:0]  vic_data_q, snp_data_q, resp_data_q;
    logic               install_q;
    mesi_state_t        inst_state_q;
    logic               need_fill;

    assign need_fill = !write_q && !snp_hit_q;  // Only a read nobody could supply

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state    <= IDLE;
            ready_en <= 1'b0;
            l2_busy  <= 1'b0;
        end else begin
            state    <= next_state;
            ready_en <= 1'b1;
            if (l2_start)
                l2_busy <= 1'b1;
            else if (l2_done)
                l2_busy <= 1'b0;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:   if (grant_valid && ready_en) next_state = LOOKUP;
            LOOKUP: begin
                // E and M writes go straight through, S needs the other copy killed
                if (lk_hit[cpu_q] && (!write_q || lk_state[cpu_q] inside {MODIFIED, EXCLUSIVE}))
                    next_state = RESPOND;
                else
                    next_state = SNOOP;
            end
            SNOOP: begin
                if (vic_q)
                    next_state = WB_VICTIM;
                else if (snoop_hit && snoop_state == MODIFIED)
                    next_state = WB_SNOOP;
                else if (!write_q && !snoop_hit)
                    next_state = FILL;
                else
                    next_state = RESPOND;
            end
            WB_VICTIM: begin
                if (l2_done)
                    next_state = snp_mod_q ? WB_SNOOP : (need_fill ? FILL : RESPOND);
            end
            WB_SNOOP, FILL: if (l2_done) next_state = RESPOND;
            RESPOND: next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    // Request and line payload
    always_ff @(posedge CLK) begin
        case (state)
            IDLE: begin
                cpu_q   <= grant_cpu;
                addr_q  <= req_addr[grant_cpu];
                write_q <= req_write[grant_cpu];
                wdata_q <= req_wdata[grant_cpu];
            end
            LOOKUP: begin
                vic_q        <= !lk_hit[cpu_q] && lk_state[cpu_q] == MODIFIED; // Dirty, other tag
                vic_tag_q    <= lk_victim_tag[cpu_q];
                vic_data_q   <= lk_data[cpu_q];
                install_q    <= write_q;
                inst_state_q <= MODIFIED;     // Silent E to M on a write hit
                resp_data_q  <= write_q ? wdata_q : lk_data[cpu_q];
            end
            SNOOP: begin
                snp_hit_q  <= snoop_hit;
                snp_mod_q  <= snoop_hit && snoop_state == MODIFIED;
                snp_data_q <= snoop_data;
                install_q  <= 1'b1;
                if (write_q)
                    inst_state_q <= MODIFIED;
                else
                    inst_state_q <= snoop_hit ? SHARED : EXCLUSIVE;
                if (!write_q && snoop_hit)
                    resp_data_q <= snoop_data;   // Cache to cache supply
            end
            FILL: if (l2_done) resp_data_q <= l2_rdata;
            default: ;
        endcase
    end

    always_comb begin
        for (int i = 0; i < CPUS; i++) begin
            req_ready[i]  = state == IDLE && ready_en && (!grant_valid || grant_cpu == CPU_W'(i));
            resp_valid[i] = state == RESPOND && cpu_q == CPU_W'(i);
            resp_rdata[i] = resp_data_q;
            upd_en[i]     = state == RESPOND && install_q && cpu_q == CPU_W'(i);
            upd_tag[i]    = addr_q.f.tag;
            upd_state[i]  = inst_state_q;
            upd_data[i]   = resp_data_q;
        end
    end

    assign done        = state == RESPOND;
    assign snoop_addr  = addr_q;     // Also drives both lookup ports
    assign snoop_apply = state == SNOOP;
    assign snoop_cmd   = state != SNOOP ? SNOOP_NONE : (write_q ? SNOOP_INVAL : SNOOP_READ);

    // One L2 access per state, started on its first cycle
    assign l2_start = state inside {WB_VICTIM, WB_SNOOP, FILL} && !l2_busy;
    assign l2_write = state != FILL;
    assign l2_wdata = state == WB_VICTIM ? vic_data_q : snp_data_q;

    always_comb begin
        l2_addr = addr_q;
        if (state == WB_VICTIM)
            l2_addr.f.tag = vic_tag_q;  // Victim shares the index
    end

endmodule

/* source/l2_memory.sv */
// Shared L2 backing store
// Fixed latency, done pulses with read data L2_LATENCY cycles after start
`timescale 1ns/10ps

module l2_memory
    import coherence_pkg::*;
(
    input  logic              CLK,
    input  logic              nRST,
    input  logic              start,
    input  logic              write,
    input  cache_addr_t       addr,
    input  logic [DATA_W-1:0] wdata,
    output logic              done,
    output logic [DATA_W-1:0] rdata
);

    logic [DATA_W-1:0]   mem [L2_WORDS];
    logic [L2_WORDS-1:0] written;    // Words never stored read back as zero
    cache_addr_t         addr_q;
    logic                busy;
    logic [L2_CNT_W-1:0] cnt;

    assign done  = busy && cnt == '0;
    assign rdata = written[addr_q.word] ? mem[addr_q.word] : '0;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            busy    <= 1'b0;
            cnt     <= '0;
            written <= '0;
        end else begin
            if (start) begin
                busy <= 1'b1;
                cnt  <= L2_CNT_W'(L2_LATENCY - 1);
            end else if (done) begin
                busy <= 1'b0;
            end else if (busy) begin
                cnt <= cnt - 1'b1;
            end
            if (start && write)
                written[addr.word] <= 1'b1;
        end
    end

    // Writes land on the start edge
    always_ff @(posedge CLK) begin
        if (start)
            addr_q <= addr;
        if (start && write)
            mem[addr.word] <= wdata;
    end

endmodule

/* source/cache_line_array.sv */
// Private direct-mapped cache, one word per line
// Requester lookup and snoop lookup run side by side on the same arrays
`timescale 1ns/10ps

module cache_line_array
    import coherence_pkg::*;
(
    input  logic              CLK,
    input  logic              nRST,
    input  cache_addr_t       lk_addr,
    output logic              lk_hit,
    output mesi_state_t       lk_state,
    output logic [DATA_W-1:0] lk_data,
    output logic [TAG_W-1:0]  lk_victim_tag,
    input  logic              upd_en,
    input  cache_addr_t       upd_addr,
    input  mesi_state_t       upd_state,
    input  logic [DATA_W-1:0] upd_data,
    input  snoop_cmd_t        snoop_cmd,
    input  cache_addr_t       snoop_addr,
    input  logic              snoop_apply,
    output logic              snoop_hit,
    output mesi_state_t       snoop_state,
    output logic [DATA_W-1:0] snoop_data
);

    logic [TAG_W-1:0]   tags   [LINES];
    logic [DATA_W-1:0]  data   [LINES];
    mesi_state_t        states [LINES];
    logic [INDEX_W-1:0] lk_idx, sn_idx, up_idx;
    logic               upd_same;     // Unit writes the line being snooped

    assign lk_idx = lk_addr.f.index;
    assign sn_idx = snoop_addr.f.index;
    assign up_idx = upd_addr.f.index;

    // Requester side
    assign lk_state      = states[lk_idx];
    assign lk_data       = data[lk_idx];
    assign lk_victim_tag = tags[lk_idx];
    assign lk_hit        = states[lk_idx] != INVALID && tags[lk_idx] == lk_addr.f.tag;

    // Snoop side, idle command never hits
    assign snoop_state = states[sn_idx];
    assign snoop_data  = data[sn_idx];
    assign snoop_hit   = snoop_cmd != SNOOP_NONE && states[sn_idx] != INVALID
                         && tags[sn_idx] == snoop_addr.f.tag;

    assign upd_same = upd_en && up_idx == sn_idx;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < LINES; i++)
                states[i] <= INVALID;
        end else begin
            if (upd_en)
                states[up_idx] <= upd_state;
            if (snoop_apply && snoop_hit && !upd_same) begin
                // M and E both drop to S on a read, anything goes to I on inval
                states[sn_idx] <= snoop_cmd == SNOOP_INVAL ? INVALID : SHARED;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (upd_en) begin
            tags[up_idx] <= upd_addr.f.tag;
            data[up_idx] <= upd_data;
        end
    end

endmodule

/* source/request_arbiter.sv */
// Round-robin request arbiter
// Grant stays locked on one processor until the unit signals done
`timescale 1ns/10ps

module request_arbiter
    import coherence_pkg::*;
(
    input  logic             CLK,
    input  logic             nRST,
    input  logic [CPUS-1:0]  req_valid,
    input  logic             busy_done,
    output logic             grant_valid,
    output logic [CPU_W-1:0] grant_cpu
);

    logic             held;        // Transaction open
    logic [CPU_W-1:0] held_cpu;
    logic [CPU_W-1:0] last;        // Last processor served
    logic [CPU_W-1:0] pick, cand;

    // First pending processor after the last one served
    always_comb begin
        pick = last;
        for (int k = CPUS; k >= 1; k--) begin
            cand = CPU_W'((int'(last) + k) % CPUS);
            if (req_valid[cand])
                pick = cand;
        end
    end

    assign grant_valid = held || (|req_valid);
    assign grant_cpu   = held ? held_cpu : pick;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            held     <= 1'b0;
            held_cpu <= '0;
            last     <= CPU_W'(CPUS - 1);  // Processor 0 wins the first tie
        end else if (held && busy_done) begin
            held <= 1'b0;
            last <= held_cpu;
        end else if (!held && (|req_valid)) begin
            held     <= 1'b1;
            held_cpu <= pick;
        end
    end

endmodule

/* source/coherence_pkg.sv */
// Coherence package
// Shared sizes, MESI and snoop encodings, and the split address word
package coherence_pkg;

    localparam int CPUS       = 2;
    localparam int CPU_W      = $clog2(CPUS);
    localparam int ADDR_W     = 16;              // Word address
    localparam int DATA_W     = 32;
    localparam int INDEX_W    = 4;
    localparam int TAG_W      = ADDR_W - INDEX_W;
    localparam int LINES      = 1 << INDEX_W;    // Lines per private cache
    localparam int L2_WORDS   = 1 << ADDR_W;
    localparam int L2_LATENCY = 3;               // Start to done, in cycles
    localparam int L2_CNT_W   = $clog2(L2_LATENCY + 1);

    // Line state, every line starts out INVALID
    typedef enum logic [1:0] {
        MODIFIED,
        EXCLUSIVE,
        SHARED,
        INVALID
    } mesi_state_t;

    // READ moves a hit to S, INVAL moves it to I
    // Both hand back the word when the line is M
    typedef enum logic [1:0] {
        SNOOP_NONE,
        SNOOP_READ,
        SNOOP_INVAL
    } snoop_cmd_t;

    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
    } addr_fields_t;

    // L2 sees a flat word, caches see tag and index
    typedef union packed {
        logic [ADDR_W-1:0] word;
        addr_fields_t      f;
    } cache_addr_t;

endpackage
